// File: common/attn_defs.svh
`ifndef ATTN_DEFS_SVH
`define ATTN_DEFS_SVH

// SRAM word and address widths
`define ATTN_WORD_W 32
`define ATTN_ADDR_W 12

// Each dimension field in a header word
`define ATTN_DIM_W 16

// Header word layout with rows in the upper half
`define ATTN_ROWS_MSB 31
`define ATTN_ROWS_LSB 16

// Columns in the lower half
`define ATTN_COLS_MSB 15
`define ATTN_COLS_LSB 0

`endif

// File: common/attn_pkg.sv
`include "attn_defs.svh"

package attn_pkg;

  // Data, address and dimension words
  typedef logic [`ATTN_WORD_W-1:0] word_t;
  typedef logic [`ATTN_ADDR_W-1:0] addr_t;
  typedef logic [`ATTN_DIM_W-1:0]  dim_t;

  // Controller states
  typedef enum logic [2:0] {
    IDLE,
    DIM_REQ,
    DIM_LOAD,
    MAC,
    DRAIN,
    WRITE,
    DONE
  } state_t;

  // Operations of one run, in order
  typedef enum logic [1:0] {
    PH_Q,
    PH_K,
    PH_V,
    PH_S
  } phase_t;

endpackage

// File: common/attn_seq_if.sv
`timescale 1ns/100ps
`include "attn_defs.svh"

interface attn_seq_if (
  input logic clk
);

  // Sequencing from the controller
  logic             load_dims;
  attn_pkg::phase_t phase;
  logic             start_phase;
  logic             step;
  logic             acc_en;
  logic             acc_first;
  logic             wr_strobe;

  // Loop status from the address generator
  logic             last_k;
  logic             last_elem;

  modport ctrl (
    input  clk,
    input  last_k,
    input  last_elem,
    output load_dims,
    output phase,
    output start_phase,
    output step,
    output acc_en,
    output acc_first,
    output wr_strobe
  );

  modport addr (
    input  clk,
    input  load_dims,
    input  phase,
    input  start_phase,
    input  step,
    output last_k,
    output last_elem
  );

  // Shared by the MAC and the write-back
  modport mac (
    input clk,
    input phase,
    input start_phase,
    input acc_en,
    input acc_first,
    input wr_strobe
  );

endinterface

// File: compile.f
+incdir+common
common/attn_pkg.sv
common/attn_seq_if.sv
src/attn_ctrl.sv
src/attn_addr_gen.sv
src/attn_mac.sv
src/attn_writeback.sv
src/attn_top.sv
dv/attn_assert.sv
dv/attn_tb.sv

// File: dv/attn_assert.sv
`timescale 1ns/100ps

module attn_assert (
  input logic            clk,
  input logic            reset_n,
  input logic            dut_ready,
  input logic            res_we,
  input logic            scr_we,
  input attn_pkg::addr_t res_waddr,
  input attn_pkg::addr_t scr_waddr
);

  // Distance between K in the result SRAM and its scratchpad copy
  attn_pkg::addr_t k_off;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      k_off <= '0;
    else if (scr_we)
      k_off <= res_waddr - scr_waddr;
  end

  // Quiet enables right out of reset
  a_reset_quiet: assert property (@(posedge clk) $rose(reset_n) |-> (!res_we && !scr_we))
    else $error("Write enable high in the first cycle after reset");

  // K copy rides along with a result write, at one fixed offset per run
  a_scr_with_res: assert property (@(posedge clk) disable iff (!reset_n)
                                   scr_we |-> (res_we && (scr_waddr == '0 ||
                                               (res_waddr - scr_waddr) == k_off)))
    else $error("Scratchpad write without a matching result write");

  // Writes happen only inside a run
  a_busy_writes: assert property (@(posedge clk) disable iff (!reset_n)
                                  dut_ready |-> (!res_we && !scr_we))
    else $error("Write while dut_ready is high");

endmodule

bind attn_top attn_assert u_assert (
  .clk       (clk),
  .reset_n   (reset_n),
  .dut_ready (dut_ready),
  .res_we    (sram_result_write_enable),
  .scr_we    (sram_scratchpad_write_enable),
  .res_waddr (sram_result_write_address),
  .scr_waddr (sram_scratchpad_write_address)
);

// File: dv/attn_tb.sv
`timescale 1ns/100ps
`include "attn_defs.svh"

module attn_tb;

  localparam int MEM_WORDS = 1 << `ATTN_ADDR_W;
  localparam int RUNS      = 7;
  localparam int WAIT_MAX  = 2000;

  logic clk;
  logic reset_n;
  logic dut_valid;
  logic dut_ready;

  // SRAM ports, one group per memory
  logic            in_we;
  attn_pkg::addr_t in_waddr;
  attn_pkg::word_t in_wdata;
  attn_pkg::addr_t in_raddr;
  attn_pkg::word_t in_rdata = '0;
  logic            wt_we;
  attn_pkg::addr_t wt_waddr;
  attn_pkg::word_t wt_wdata;
  attn_pkg::addr_t wt_raddr;
  attn_pkg::word_t wt_rdata = '0;
  logic            res_we;
  attn_pkg::addr_t res_waddr;
  attn_pkg::word_t res_wdata;
  attn_pkg::addr_t res_raddr;
  attn_pkg::word_t res_rdata = '0;
  logic            scr_we;
  attn_pkg::addr_t scr_waddr;
  attn_pkg::word_t scr_wdata;
  attn_pkg::addr_t scr_raddr;
  attn_pkg::word_t scr_rdata = '0;

  attn_pkg::word_t in_mem  [MEM_WORDS];
  attn_pkg::word_t wt_mem  [MEM_WORDS];
  attn_pkg::word_t res_mem [MEM_WORDS];
  attn_pkg::word_t scr_mem [MEM_WORDS];

  // Operands of the current run, W index 0..2 is Wq, Wk, Wv
  attn_pkg::word_t i_mat [4][4];
  attn_pkg::word_t w_mat [3][4][4];
  int    n_dim;
  int    d_dim;
  int    e_dim;
  int    errors;
  int    checks;
  int    res_writes;
  int    scr_writes;
  logic  aborted;
  string test_name;
  event  run_finished;

  attn_top dut0 (
    .clk                           (clk),
    .reset_n                       (reset_n),
    .dut_valid                     (dut_valid),
    .dut_ready                     (dut_ready),
    .sram_input_write_enable       (in_we),
    .sram_input_write_address      (in_waddr),
    .sram_input_write_data         (in_wdata),
    .sram_input_read_address       (in_raddr),
    .sram_input_read_data          (in_rdata),
    .sram_weight_write_enable      (wt_we),
    .sram_weight_write_address     (wt_waddr),
    .sram_weight_write_data        (wt_wdata),
    .sram_weight_read_address      (wt_raddr),
    .sram_weight_read_data         (wt_rdata),
    .sram_result_write_enable      (res_we),
    .sram_result_write_address     (res_waddr),
    .sram_result_write_data        (res_wdata),
    .sram_result_read_address      (res_raddr),
    .sram_result_read_data         (res_rdata),
    .sram_scratchpad_write_enable  (scr_we),
    .sram_scratchpad_write_address (scr_waddr),
    .sram_scratchpad_write_data    (scr_wdata),
    .sram_scratchpad_read_address  (scr_raddr),
    .sram_scratchpad_read_data     (scr_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------
  // SRAM models, one cycle read latency
  always @(posedge clk)
  begin
    in_rdata  <= in_mem[in_raddr];
    wt_rdata  <= wt_mem[wt_raddr];
    res_rdata <= res_mem[res_raddr];
    scr_rdata <= scr_mem[scr_raddr];
    if (in_we)
      in_mem[in_waddr] = in_wdata;
    if (wt_we)
      wt_mem[wt_waddr] = wt_wdata;
    if (res_we)
      res_mem[res_waddr] = res_wdata;
    if (scr_we)
      scr_mem[scr_waddr] = scr_wdata;
  end

  // Write monitor
  always @(posedge clk)
  begin
    if (in_we !== 1'b0 || wt_we !== 1'b0)
    begin
      $display("Input or weight SRAM write enable raised in %s", test_name);
      errors++;
    end
    if (reset_n && res_we)
      res_writes++;
    if (reset_n && scr_we)
    begin
      scr_writes++;
      if (int'(scr_waddr) >= n_dim * e_dim)
      begin
        $display("Scratchpad written at %0d, past the end of K in %s", scr_waddr, test_name);
        errors++;
      end
    end
    if (reset_n && dut_ready && (res_we || scr_we))
    begin
      $display("SRAM written while dut_ready is high in %s", test_name);
      errors++;
    end
  end

  // --------------------
  // Reference model
  function automatic attn_pkg::word_t proj_ref(input int w, input int row, input int col);
    attn_pkg::word_t sum;
    sum = '0;
    for (int k = 0; k < d_dim; k++)
      sum += i_mat[row][k] * w_mat[w][k][col];
    return sum;
  endfunction

  // Expected word of the result SRAM, Q K V then S
  function automatic attn_pkg::word_t result_ref(input int addr);
    int              ne;
    int              idx;
    attn_pkg::word_t sum;
    ne  = n_dim * e_dim;
    sum = '0;
    if (addr < 3 * ne)
    begin
      idx = addr % ne;
      sum = proj_ref(addr / ne, idx / e_dim, idx % e_dim);
    end
    else
    begin
      idx = addr - 3 * ne;
      for (int e = 0; e < e_dim; e++)
        sum += proj_ref(0, idx / n_dim, e) * proj_ref(1, idx % n_dim, e);
    end
    return sum;
  endfunction

  // Compares SRAM contents once a run has finished
  always @(run_finished)
  begin
    for (int a = 0; a < 3 * n_dim * e_dim + n_dim * n_dim; a++)
    begin
      checks++;
      if (res_mem[a] !== result_ref(a))
      begin
        $display("FAILED %s result[%0d] expected %h actual %h",
                 test_name, a, result_ref(a), res_mem[a]);
        errors++;
      end
    end
    for (int a = 0; a < n_dim * e_dim; a++)
    begin
      checks++;
      if (scr_mem[a] !== proj_ref(1, a / e_dim, a % e_dim))
      begin
        $display("FAILED %s scratchpad[%0d] expected %h actual %h",
                 test_name, a, proj_ref(1, a / e_dim, a % e_dim), scr_mem[a]);
        errors++;
      end
    end
    checks++;
    if (res_writes != 3 * n_dim * e_dim + n_dim * n_dim)
    begin
      $display("FAILED %s result writes expected %0d actual %0d",
               test_name, 3 * n_dim * e_dim + n_dim * n_dim, res_writes);
      errors++;
    end
    checks++;
    if (scr_writes != n_dim * e_dim)
    begin
      $display("FAILED %s scratchpad writes expected %0d actual %0d",
               test_name, n_dim * e_dim, scr_writes);
      errors++;
    end
  end

  // --------------------
  // Fills all four SRAMs for one run
  task automatic load_memories(input int n, input int d, input int e);
    n_dim = n;
    d_dim = d;
    e_dim = e;
    for (int a = 0; a < MEM_WORDS; a++)
    begin
      in_mem[a]  = '0;
      wt_mem[a]  = '0;
      res_mem[a] = 32'h5A5A_0000 ^ a;
      scr_mem[a] = 32'hC3C3_0000 ^ a;
    end
    in_mem[0] = {attn_pkg::dim_t'(n), attn_pkg::dim_t'(d)};
    wt_mem[0] = {attn_pkg::dim_t'(d), attn_pkg::dim_t'(e)};
    for (int r = 0; r < n; r++)
      for (int c = 0; c < d; c++)
      begin
        i_mat[r][c] = $urandom;
        in_mem[1 + r * d + c] = i_mat[r][c];
      end
    // Weights column by column
    for (int w = 0; w < 3; w++)
      for (int c = 0; c < e; c++)
        for (int k = 0; k < d; k++)
        begin
          w_mat[w][k][c] = $urandom;
          wt_mem[1 + w * d * e + c * d + k] = w_mat[w][k][c];
        end
  endtask

  task automatic do_run(input int r, input int n, input int d, input int e);
    int cnt;
    test_name = $sformatf("run %0d (N %0d D %0d E %0d)", r, n, d, e);
    load_memories(n, d, e);
    res_writes = 0;
    scr_writes = 0;
    checks++;
    if (dut_ready !== 1'b1)
    begin
      $display("FAILED %s dut_ready before start expected 1 actual %b", test_name, dut_ready);
      errors++;
    end
    dut_valid = 1'b1;
    @(negedge clk);
    dut_valid = 1'b0;
    cnt = 0;
    while (dut_ready === 1'b1 && cnt < WAIT_MAX)
    begin
      @(negedge clk);
      cnt++;
    end
    if (dut_ready === 1'b1)
    begin
      $display("Timeout, dut_ready never went low in %s", test_name);
      errors++;
      aborted = 1'b1;
      return;
    end
    cnt = 0;
    while (dut_ready !== 1'b1 && cnt < WAIT_MAX)
    begin
      @(negedge clk);
      cnt++;
    end
    if (dut_ready !== 1'b1)
    begin
      $display("Timeout, dut_ready never returned high in %s", test_name);
      errors++;
      aborted = 1'b1;
      return;
    end
    -> run_finished;
    @(negedge clk);
  endtask

  // --------------------
  initial
  begin
    int n;
    int d;
    int e;
    void'($urandom(88));
    reset_n    = 1'b0;
    dut_valid  = 1'b0;
    errors     = 0;
    checks     = 0;
    res_writes = 0;
    scr_writes = 0;
    aborted    = 1'b0;
    test_name  = "reset";
    load_memories(1, 1, 1);
    repeat (4) @(negedge clk);
    reset_n = 1'b1;

    // Idle after reset, nothing may be written
    repeat (6) @(negedge clk);
    checks++;
    if (dut_ready !== 1'b1)
    begin
      $display("FAILED reset dut_ready expected 1 actual %b", dut_ready);
      errors++;
    end
    checks++;
    if (res_writes != 0 || scr_writes != 0)
    begin
      $display("FAILED reset writes expected 0 actual %0d", res_writes + scr_writes);
      errors++;
    end

    for (int r = 0; r < RUNS && !aborted; r++)
    begin
      if (r == 0)
        do_run(r, 1, 1, 1);
      else if (r == 1)
        do_run(r, 4, 4, 4);
      else
      begin
        n = 1 + ($urandom % 4);
        d = 1 + ($urandom % 4);
        e = 1 + ($urandom % 4);
        do_run(r, n, d, e);
      end
    end

    $display("Finished with %0d checks and %0d errors", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: run.sh
#!/bin/sh
# Builds the attention testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module attn_tb -o attn_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/attn_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation passed"
exit 0

// File: src/attn_addr_gen.sv
`timescale 1ns/100ps
`include "attn_defs.svh"

module attn_addr_gen (
  input  logic            clk,
  input  logic            reset_n,
  attn_seq_if.addr        seq,
  input  attn_pkg::word_t a_rdata,
  input  attn_pkg::word_t b_rdata,
  output attn_pkg::addr_t a_addr,
  output attn_pkg::addr_t b_addr
);

  localparam attn_pkg::dim_t  DIM_ONE  = 1;
  localparam attn_pkg::addr_t ADDR_ONE = 1;

  attn_pkg::dim_t  n_dim;
  attn_pkg::dim_t  d_dim;
  attn_pkg::dim_t  e_dim;
  attn_pkg::dim_t  k_cnt;
  attn_pkg::dim_t  col_cnt;
  attn_pkg::dim_t  row_cnt;
  attn_pkg::dim_t  k_len;
  attn_pkg::dim_t  col_len;
  attn_pkg::addr_t a_ptr;
  attn_pkg::addr_t a_row_base;
  attn_pkg::addr_t b_ptr;
  attn_pkg::addr_t b_mat_base;
  logic            k_end;
  logic            col_end;
  logic            row_end;
  logic            last_elem_q;

  // Header words arrive one cycle after address 0
  always_ff @(posedge clk)
  begin
    if (seq.load_dims)
    begin
      n_dim <= a_rdata[`ATTN_ROWS_MSB:`ATTN_ROWS_LSB];
      d_dim <= a_rdata[`ATTN_COLS_MSB:`ATTN_COLS_LSB];
      e_dim <= b_rdata[`ATTN_COLS_MSB:`ATTN_COLS_LSB];
    end
  end

  // Scores walk rows of Q and K, so the inner length is E
  assign k_len   = (seq.phase == attn_pkg::PH_S) ? e_dim : d_dim;
  assign col_len = (seq.phase == attn_pkg::PH_S) ? n_dim : e_dim;
  assign k_end   = (k_cnt == k_len - DIM_ONE);
  assign col_end = (col_cnt == col_len - DIM_ONE);
  assign row_end = (row_cnt == n_dim - DIM_ONE);

  // --------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      k_cnt       <= '0;
      col_cnt     <= '0;
      row_cnt     <= '0;
      a_ptr       <= '0;
      a_row_base  <= '0;
      b_ptr       <= '0;
      b_mat_base  <= '0;
      last_elem_q <= 1'b0;
    end
    else if (seq.start_phase)
    begin
      k_cnt       <= '0;
      col_cnt     <= '0;
      row_cnt     <= '0;
      last_elem_q <= 1'b0;
      case (seq.phase)
        // Run start, Q reads I and Wq from address 1
        attn_pkg::PH_S:
        begin
          a_ptr      <= ADDR_ONE;
          a_row_base <= ADDR_ONE;
          b_ptr      <= ADDR_ONE;
          b_mat_base <= ADDR_ONE;
        end
        // Scores read Q and K from address 0
        attn_pkg::PH_V:
        begin
          a_ptr      <= '0;
          a_row_base <= '0;
          b_ptr      <= '0;
          b_mat_base <= '0;
        end
        // Next weight matrix starts right where the last one ended
        default:
        begin
          a_ptr      <= ADDR_ONE;
          a_row_base <= ADDR_ONE;
          b_mat_base <= b_ptr;
        end
      endcase
    end
    else if (seq.step)
    begin
      if (!k_end)
      begin
        k_cnt <= k_cnt + DIM_ONE;
        a_ptr <= a_ptr + ADDR_ONE;
        b_ptr <= b_ptr + ADDR_ONE;
      end
      else
      begin
        k_cnt <= '0;
        if (!col_end)
        begin
          // Same row again, next column
          col_cnt <= col_cnt + DIM_ONE;
          a_ptr   <= a_row_base;
          b_ptr   <= b_ptr + ADDR_ONE;
        end
        else if (!row_end)
        begin
          col_cnt    <= '0;
          row_cnt    <= row_cnt + DIM_ONE;
          a_ptr      <= a_ptr + ADDR_ONE;
          a_row_base <= a_ptr + ADDR_ONE;
          b_ptr      <= b_mat_base;
        end
        else
        begin
          // Last dot product of the phase, park at the header address
          col_cnt     <= '0;
          row_cnt     <= '0;
          last_elem_q <= 1'b1;
          a_ptr       <= '0;
          a_row_base  <= '0;
          b_ptr       <= (seq.phase == attn_pkg::PH_S) ? '0 : b_ptr + ADDR_ONE;
        end
      end
    end
  end

  assign seq.last_k    = k_end;
  assign seq.last_elem = last_elem_q;

  assign a_addr = a_ptr;
  assign b_addr = b_ptr;

endmodule

// File: src/attn_ctrl.sv
`timescale 1ns/100ps

module attn_ctrl (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     dut_valid,
  output logic     dut_ready,
  attn_seq_if.ctrl seq
);

  attn_pkg::state_t state;
  attn_pkg::state_t state_next;
  attn_pkg::phase_t phase;
  logic             start_phase;
  logic             load_dims;
  logic             step;
  logic             wr_strobe;
  logic             acc_en_q;
  logic             acc_first_q;

  // --------------------
  // State register
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      state <= attn_pkg::IDLE;
    else
      state <= state_next;
  end

  // Next state and per-state pulses
  always_comb
  begin
    state_next  = state;
    start_phase = 1'b0;
    load_dims   = 1'b0;
    step        = 1'b0;
    wr_strobe   = 1'b0;
    case (state)
      attn_pkg::IDLE:
      begin
        if (dut_valid)
          state_next = attn_pkg::DIM_REQ;
      end
      attn_pkg::DIM_REQ:
        state_next = attn_pkg::DIM_LOAD;
      attn_pkg::DIM_LOAD:
      begin
        load_dims   = 1'b1;
        start_phase = 1'b1;
        state_next  = attn_pkg::MAC;
      end
      attn_pkg::MAC:
      begin
        step = 1'b1;
        if (seq.last_k)
          state_next = attn_pkg::DRAIN;
      end
      attn_pkg::DRAIN:
        state_next = attn_pkg::WRITE;
      attn_pkg::WRITE:
      begin
        wr_strobe = 1'b1;
        if (!seq.last_elem)
          state_next = attn_pkg::MAC;
        else if (phase == attn_pkg::PH_S)
          state_next = attn_pkg::DONE;
        else
        begin
          start_phase = 1'b1;
          state_next  = attn_pkg::MAC;
        end
      end
      default:
        state_next = attn_pkg::IDLE;
    endcase
  end

  // --------------------
  // Phase advances on each start pulse, S wraps back to Q
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      phase <= attn_pkg::PH_S;
    else if (start_phase)
      phase <= attn_pkg::phase_t'(phase + 2'd1);
  end

  // Accumulate one cycle behind the read address
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      acc_en_q    <= 1'b0;
      acc_first_q <= 1'b0;
    end
    else
    begin
      acc_en_q    <= (state == attn_pkg::MAC);
      acc_first_q <= (state == attn_pkg::MAC) && !acc_en_q;
    end
  end

  assign seq.phase       = phase;
  assign seq.start_phase = start_phase;
  assign seq.load_dims   = load_dims;
  assign seq.step        = step;
  assign seq.wr_strobe   = wr_strobe;
  assign seq.acc_en      = acc_en_q;
  assign seq.acc_first   = acc_first_q;

  assign dut_ready = (state == attn_pkg::IDLE) || (state == attn_pkg::DONE);

endmodule

// File: src/attn_mac.sv
`timescale 1ns/100ps

module attn_mac (
  input  logic            clk,
  input  logic            reset_n,
  attn_seq_if.mac         seq,
  input  attn_pkg::word_t in_rdata,
  input  attn_pkg::word_t wt_rdata,
  input  attn_pkg::word_t res_rdata,
  input  attn_pkg::word_t scr_rdata,
  output attn_pkg::word_t acc
);

  attn_pkg::word_t op_a;
  attn_pkg::word_t op_b;
  attn_pkg::word_t product;
  logic            scores;

  // --------------------
  // Operand select
  assign scores = (seq.phase == attn_pkg::PH_S);

  // Q rows against K rows for scores, I against weights otherwise
  assign op_a = scores ? res_rdata : in_rdata;
  assign op_b = scores ? scr_rdata : wt_rdata;

  // Wraps modulo 2^32
  assign product = op_a * op_b;

  // --------------------
  // Accumulator
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      acc <= '0;
    else if (seq.acc_en)
    begin
      // First element restarts the sum
      if (seq.acc_first)
        acc <= product;
      else
        acc <= acc + product;
    end
  end

endmodule

// File: src/attn_top.sv
`timescale 1ns/100ps
`include "attn_defs.svh"

module attn_top (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    dut_valid,
  output logic                    dut_ready,

  output logic                    sram_input_write_enable,
  output logic [`ATTN_ADDR_W-1:0] sram_input_write_address,
  output logic [`ATTN_WORD_W-1:0] sram_input_write_data,
  output logic [`ATTN_ADDR_W-1:0] sram_input_read_address,
  input  logic [`ATTN_WORD_W-1:0] sram_input_read_data,

  output logic                    sram_weight_write_enable,
  output logic [`ATTN_ADDR_W-1:0] sram_weight_write_address,
  output logic [`ATTN_WORD_W-1:0] sram_weight_write_data,
  output logic [`ATTN_ADDR_W-1:0] sram_weight_read_address,
  input  logic [`ATTN_WORD_W-1:0] sram_weight_read_data,

  output logic                    sram_result_write_enable,
  output logic [`ATTN_ADDR_W-1:0] sram_result_write_address,
  output logic [`ATTN_WORD_W-1:0] sram_result_write_data,
  output logic [`ATTN_ADDR_W-1:0] sram_result_read_address,
  input  logic [`ATTN_WORD_W-1:0] sram_result_read_data,

  output logic                    sram_scratchpad_write_enable,
  output logic [`ATTN_ADDR_W-1:0] sram_scratchpad_write_address,
  output logic [`ATTN_WORD_W-1:0] sram_scratchpad_write_data,
  output logic [`ATTN_ADDR_W-1:0] sram_scratchpad_read_address,
  input  logic [`ATTN_WORD_W-1:0] sram_scratchpad_read_data
);

  attn_pkg::addr_t a_addr;
  attn_pkg::addr_t b_addr;
  attn_pkg::word_t acc;

  attn_seq_if seq_if (.clk(clk));

  attn_ctrl u_ctrl (
    .clk       (clk),
    .reset_n   (reset_n),
    .dut_valid (dut_valid),
    .dut_ready (dut_ready),
    .seq       (seq_if.ctrl)
  );

  attn_addr_gen u_addr_gen (
    .clk     (clk),
    .reset_n (reset_n),
    .seq     (seq_if.addr),
    .a_rdata (sram_input_read_data),
    .b_rdata (sram_weight_read_data),
    .a_addr  (a_addr),
    .b_addr  (b_addr)
  );

  attn_mac u_mac (
    .clk       (clk),
    .reset_n   (reset_n),
    .seq       (seq_if.mac),
    .in_rdata  (sram_input_read_data),
    .wt_rdata  (sram_weight_read_data),
    .res_rdata (sram_result_read_data),
    .scr_rdata (sram_scratchpad_read_data),
    .acc       (acc)
  );

  attn_writeback u_writeback (
    .clk       (clk),
    .reset_n   (reset_n),
    .seq       (seq_if.mac),
    .acc       (acc),
    .res_we    (sram_result_write_enable),
    .scr_we    (sram_scratchpad_write_enable),
    .res_waddr (sram_result_write_address),
    .scr_waddr (sram_scratchpad_write_address),
    .res_wdata (sram_result_write_data),
    .scr_wdata (sram_scratchpad_write_data)
  );

  // --------------------
  // A side feeds I or Q, B side feeds weights or K
  assign sram_input_read_address      = a_addr;
  assign sram_result_read_address     = a_addr;
  assign sram_weight_read_address     = b_addr;
  assign sram_scratchpad_read_address = b_addr;

  // Input and weight SRAMs are read only
  assign sram_input_write_enable   = 1'b0;
  assign sram_input_write_address  = '0;
  assign sram_input_write_data     = '0;
  assign sram_weight_write_enable  = 1'b0;
  assign sram_weight_write_address = '0;
  assign sram_weight_write_data    = '0;

endmodule

// File: src/attn_writeback.sv
`timescale 1ns/100ps

module attn_writeback (
  input  logic            clk,
  input  logic            reset_n,
  attn_seq_if.mac         seq,
  input  attn_pkg::word_t acc,
  output logic            res_we,
  output logic            scr_we,
  output attn_pkg::addr_t res_waddr,
  output attn_pkg::addr_t scr_waddr,
  output attn_pkg::word_t res_wdata,
  output attn_pkg::word_t scr_wdata
);

  localparam attn_pkg::addr_t ADDR_ONE = 1;

  attn_pkg::addr_t res_ptr;
  attn_pkg::addr_t scr_ptr;
  logic            run_start;
  logic            scr_hit;

  // Start pulse leaving PH_S begins a new run with Q
  assign run_start = seq.start_phase && (seq.phase == attn_pkg::PH_S);

  // K also goes to the scratchpad
  assign scr_hit = seq.wr_strobe && (seq.phase == attn_pkg::PH_K);

  // --------------------
  // Write pointers
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      res_ptr <= '0;
      scr_ptr <= '0;
    end
    else if (run_start)
    begin
      res_ptr <= '0;
      scr_ptr <= '0;
    end
    else
    begin
      // Q, K, V and S land back to back
      if (seq.wr_strobe)
        res_ptr <= res_ptr + ADDR_ONE;
      if (scr_hit)
        scr_ptr <= scr_ptr + ADDR_ONE;
    end
  end

  // --------------------
  assign res_we    = seq.wr_strobe;
  assign res_waddr = res_ptr;
  assign res_wdata = acc;

  assign scr_we    = scr_hit;
  assign scr_waddr = scr_ptr;
  assign scr_wdata = acc;

endmodule
